//--- common/soc_periph_pkg.sv
// shared widths, address map, register offsets and event positions, imported by every RTL block
package soc_periph_pkg;

  // bus and block widths
  localparam int unsigned APB_ADDR_WIDTH = 32;
  localparam int unsigned APB_DATA_WIDTH = 32;
  localparam int unsigned N_GPIO         = 16;
  localparam int unsigned N_FC_EVENTS    = 32;
  localparam int unsigned JTAG_REG_WIDTH = 8;

  //////////////////////////////////////////////////
  // address map
  //////////////////////////////////////////////////

  // region field sits in paddr[15:12]
  localparam int unsigned PERIPH_SEL_LSB   = 12;
  localparam int unsigned PERIPH_SEL_WIDTH = 4;

  // other region codes are unmapped and get pslverr
  typedef enum logic [PERIPH_SEL_WIDTH-1:0] {
    SEL_GPIO     = 4'd0,
    SEL_TIMER    = 4'd1,
    SEL_SOC_CTRL = 4'd2
  } periph_sel_e;

  // word offset inside a region, paddr[5:2]
  localparam int unsigned REG_OFFSET_LSB   = 2;
  localparam int unsigned REG_OFFSET_WIDTH = 4;

  typedef enum logic [REG_OFFSET_WIDTH-1:0] {
    GPIO_DIR        = 4'd0,
    GPIO_OUT        = 4'd1,
    GPIO_IN         = 4'd2,
    GPIO_INT_EN     = 4'd3,
    GPIO_INT_STATUS = 4'd4
  } gpio_reg_e;

  typedef enum logic [REG_OFFSET_WIDTH-1:0] {
    TIMER_CFG   = 4'd0,
    TIMER_COUNT = 4'd1,
    TIMER_CMP   = 4'd2
  } timer_reg_e;

  // bit fields of TIMER_CFG
  localparam int unsigned TIMER_CFG_EN_BIT  = 0;
  localparam int unsigned TIMER_CFG_REF_BIT = 1;

  typedef enum logic [REG_OFFSET_WIDTH-1:0] {
    CTRL_VERSION  = 4'd0,
    CTRL_BOOTADDR = 4'd1,
    CTRL_FETCH_EN = 4'd2,
    CTRL_JTAG     = 4'd3
  } soc_ctrl_reg_e;

  // reset values and fixed words
  localparam logic [31:0] BOOT_ADDR_RESET = 32'h1A00_0080;
  localparam logic [31:0] SOC_VERSION     = 32'h0001_0002;

  //////////////////////////////////////////////////
  // fc event vector bit positions
  //////////////////////////////////////////////////
  localparam int unsigned FC_EVT_TIMER_MTIME = 7;
  localparam int unsigned FC_EVT_TIMER       = 16;
  localparam int unsigned FC_EVT_REF_EDGE    = 23;
  // bit 24 was reserved, now carries gpio directly
  localparam int unsigned FC_EVT_GPIO        = 24;

endpackage

//--- source/periph_bus_decoder.sv
`timescale 1ns/100ps
// combinational APB decoder, selects gpio, timer or soc control and muxes read data back
module periph_bus_decoder
  import soc_periph_pkg::*;
(
  input  logic [APB_ADDR_WIDTH-1:0] paddr_i,
  input  logic                      pwrite_i,
  input  logic                      psel_i,
  input  logic                      penable_i,
  // read data from the three slaves
  input  logic [APB_DATA_WIDTH-1:0] prdata_gpio_i,
  input  logic [APB_DATA_WIDTH-1:0] prdata_timer_i,
  input  logic [APB_DATA_WIDTH-1:0] prdata_ctrl_i,
  output logic                      psel_gpio_o,
  output logic                      psel_timer_o,
  output logic                      psel_ctrl_o,
  output logic [APB_DATA_WIDTH-1:0] prdata_o,
  output logic                      pready_o,
  output logic                      pslverr_o
);

  periph_sel_e region;
  logic        mapped;

  // region code from the upper address nibble
  assign region = periph_sel_e'(paddr_i[PERIPH_SEL_LSB +: PERIPH_SEL_WIDTH]);

  always_comb begin
    psel_gpio_o  = 1'b0;
    psel_timer_o = 1'b0;
    psel_ctrl_o  = 1'b0;
    prdata_o     = '0;
    mapped       = 1'b1;
    case (region)
      SEL_GPIO: begin
        psel_gpio_o = psel_i;
        prdata_o    = prdata_gpio_i;
      end
      SEL_TIMER: begin
        psel_timer_o = psel_i;
        prdata_o     = prdata_timer_i;
      end
      SEL_SOC_CTRL: begin
        psel_ctrl_o = psel_i;
        prdata_o    = prdata_ctrl_i;
      end
      // unmapped, no slave sees psel
      default: mapped = 1'b0;
    endcase
    // read data only meaningful on reads
    if (pwrite_i) begin
      prdata_o = '0;
    end
  end

  // zero wait states
  assign pready_o  = 1'b1;
  // error only in the access cycle of an unmapped transfer
  assign pslverr_o = psel_i & penable_i & ~mapped;

endmodule

//--- gpio/apb_gpio.sv
`timescale 1ns/100ps
// APB GPIO block with direction and output regs, synchronized input and rising-edge interrupts
module apb_gpio
  import soc_periph_pkg::*;
(
  input  logic                      clk_i,
  input  logic                      arst_n_i,
  input  logic                      psel_i,
  input  logic                      penable_i,
  input  logic                      pwrite_i,
  input  logic [APB_ADDR_WIDTH-1:0] paddr_i,
  input  logic [APB_DATA_WIDTH-1:0] pwdata_i,
  input  logic [N_GPIO-1:0]         gpio_in_i,
  output logic [APB_DATA_WIDTH-1:0] prdata_o,
  output logic [N_GPIO-1:0]         gpio_out_o,
  output logic [N_GPIO-1:0]         gpio_oe_o,
  output logic                      gpio_event_o
);

  gpio_reg_e         reg_off;
  logic              wr_en;
  logic [N_GPIO-1:0] dir_q;
  logic [N_GPIO-1:0] out_q;
  logic [N_GPIO-1:0] int_en_q;
  logic [N_GPIO-1:0] status_q;
  logic [N_GPIO-1:0] sync1_q;
  logic [N_GPIO-1:0] sync2_q;
  logic [N_GPIO-1:0] prev_q;
  logic [N_GPIO-1:0] rise;
  logic [N_GPIO-1:0] clr;

  assign reg_off = gpio_reg_e'(paddr_i[REG_OFFSET_LSB +: REG_OFFSET_WIDTH]);
  // write lands at the end of the access cycle
  assign wr_en   = psel_i & penable_i & pwrite_i;

  // 2-flop sync then one flop for edge detect
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      sync1_q <= '0;
      sync2_q <= '0;
      prev_q  <= '0;
    end else begin
      sync1_q <= gpio_in_i;
      sync2_q <= sync1_q;
      prev_q  <= sync2_q;
    end
  end

  assign rise = sync2_q & ~prev_q;
  // w1c mask, only on a status write
  assign clr  = (wr_en && reg_off == GPIO_INT_STATUS) ? pwdata_i[N_GPIO-1:0] : '0;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      dir_q    <= '0;
      out_q    <= '0;
      int_en_q <= '0;
      status_q <= '0;
    end else begin
      if (wr_en && reg_off == GPIO_DIR) begin
        dir_q <= pwdata_i[N_GPIO-1:0];
      end
      if (wr_en && reg_off == GPIO_OUT) begin
        out_q <= pwdata_i[N_GPIO-1:0];
      end
      if (wr_en && reg_off == GPIO_INT_EN) begin
        int_en_q <= pwdata_i[N_GPIO-1:0];
      end
      // a new edge beats a same-cycle clear
      status_q <= (status_q & ~clr) | (rise & int_en_q);
    end
  end

  always_comb begin
    prdata_o = '0;
    case (reg_off)
      GPIO_DIR:        prdata_o[N_GPIO-1:0] = dir_q;
      GPIO_OUT:        prdata_o[N_GPIO-1:0] = out_q;
      GPIO_IN:         prdata_o[N_GPIO-1:0] = sync2_q;
      GPIO_INT_EN:     prdata_o[N_GPIO-1:0] = int_en_q;
      GPIO_INT_STATUS: prdata_o[N_GPIO-1:0] = status_q;
      default:         prdata_o = '0;
    endcase
  end

  assign gpio_out_o   = out_q;
  assign gpio_oe_o    = dir_q;
  // level, held while anything is pending
  assign gpio_event_o = |status_q;

endmodule

//--- timer/apb_timer.sv
`timescale 1ns/100ps
// APB compare timer counting clocks or slow-clock ticks, also flags every slow-clock edge
module apb_timer
  import soc_periph_pkg::*;
(
  input  logic                      clk_i,
  input  logic                      arst_n_i,
  input  logic                      psel_i,
  input  logic                      penable_i,
  input  logic                      pwrite_i,
  input  logic [APB_ADDR_WIDTH-1:0] paddr_i,
  input  logic [APB_DATA_WIDTH-1:0] pwdata_i,
  input  logic                      slow_clk_i,
  input  logic                      stoptimer_i,
  output logic [APB_DATA_WIDTH-1:0] prdata_o,
  output logic                      timer_event_o,
  output logic                      ref_edge_event_o
);

  timer_reg_e                reg_off;
  logic                      wr_en;
  logic                      enable_q;
  logic                      ref_mode_q;
  logic [APB_DATA_WIDTH-1:0] count_q;
  logic [APB_DATA_WIDTH-1:0] cmp_q;
  logic                      slow_s1_q;
  logic                      slow_s2_q;
  logic                      slow_prev_q;
  logic                      slow_rise;
  logic                      slow_edge;
  logic                      tick;

  assign reg_off = timer_reg_e'(paddr_i[REG_OFFSET_LSB +: REG_OFFSET_WIDTH]);
  assign wr_en   = psel_i & penable_i & pwrite_i;

  //////////////////////////////////////////////////
  // slow clock sync and edge detect
  //////////////////////////////////////////////////
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      slow_s1_q        <= 1'b0;
      slow_s2_q        <= 1'b0;
      slow_prev_q      <= 1'b0;
      ref_edge_event_o <= 1'b0;
    end else begin
      slow_s1_q        <= slow_clk_i;
      slow_s2_q        <= slow_s1_q;
      slow_prev_q      <= slow_s2_q;
      // registered, so pulse starts 3 edges after the slow edge
      ref_edge_event_o <= slow_edge;
    end
  end

  assign slow_rise = slow_s2_q & ~slow_prev_q;
  assign slow_edge = slow_s2_q ^ slow_prev_q;

  // ref mode steps on synced rising edges only
  assign tick = enable_q & ~stoptimer_i & (ref_mode_q ? slow_rise : 1'b1);

  //////////////////////////////////////////////////
  // config, counter and compare
  //////////////////////////////////////////////////
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      enable_q      <= 1'b0;
      ref_mode_q    <= 1'b0;
      cmp_q         <= '0;
      count_q       <= '0;
      timer_event_o <= 1'b0;
    end else begin
      timer_event_o <= 1'b0;
      if (wr_en && reg_off == TIMER_CFG) begin
        enable_q   <= pwdata_i[TIMER_CFG_EN_BIT];
        ref_mode_q <= pwdata_i[TIMER_CFG_REF_BIT];
      end
      if (wr_en && reg_off == TIMER_CMP) begin
        cmp_q <= pwdata_i;
      end
      // a direct load has priority over counting
      if (wr_en && reg_off == TIMER_COUNT) begin
        count_q <= pwdata_i;
      end else if (tick) begin
        if (count_q == cmp_q) begin
          // match, wrap and pulse, period is cmp+1
          count_q       <= '0;
          timer_event_o <= 1'b1;
        end else begin
          count_q <= count_q + 1'b1;
        end
      end
    end
  end

  always_comb begin
    prdata_o = '0;
    case (reg_off)
      TIMER_CFG: begin
        prdata_o[TIMER_CFG_EN_BIT]  = enable_q;
        prdata_o[TIMER_CFG_REF_BIT] = ref_mode_q;
      end
      TIMER_COUNT: prdata_o = count_q;
      TIMER_CMP:   prdata_o = cmp_q;
      default:     prdata_o = '0;
    endcase
  end

endmodule

//--- source/apb_soc_ctrl.sv
`timescale 1ns/100ps
// APB soc control registers for boot address, fetch enable, jtag exchange and version
module apb_soc_ctrl
  import soc_periph_pkg::*;
(
  input  logic                      clk_i,
  input  logic                      arst_n_i,
  input  logic                      psel_i,
  input  logic                      penable_i,
  input  logic                      pwrite_i,
  input  logic [APB_ADDR_WIDTH-1:0] paddr_i,
  input  logic [APB_DATA_WIDTH-1:0] pwdata_i,
  // pin override of fetch enable
  input  logic                      fc_fetch_en_valid_i,
  input  logic                      fc_fetch_en_i,
  input  logic [JTAG_REG_WIDTH-1:0] soc_jtag_reg_i,
  output logic [APB_DATA_WIDTH-1:0] prdata_o,
  output logic [APB_DATA_WIDTH-1:0] fc_bootaddr_o,
  output logic                      fc_fetchen_o,
  output logic [JTAG_REG_WIDTH-1:0] soc_jtag_reg_o
);

  soc_ctrl_reg_e reg_off;
  logic          wr_en;

  assign reg_off = soc_ctrl_reg_e'(paddr_i[REG_OFFSET_LSB +: REG_OFFSET_WIDTH]);
  assign wr_en   = psel_i & penable_i & pwrite_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      fc_bootaddr_o  <= BOOT_ADDR_RESET;
      fc_fetchen_o   <= 1'b0;
      soc_jtag_reg_o <= '0;
    end else begin
      if (wr_en && reg_off == CTRL_BOOTADDR) begin
        fc_bootaddr_o <= pwdata_i;
      end
      // strobe wins over a bus write on the same edge
      if (fc_fetch_en_valid_i) begin
        fc_fetchen_o <= fc_fetch_en_i;
      end else if (wr_en && reg_off == CTRL_FETCH_EN) begin
        fc_fetchen_o <= pwdata_i[0];
      end
      if (wr_en && reg_off == CTRL_JTAG) begin
        soc_jtag_reg_o <= pwdata_i[JTAG_REG_WIDTH-1:0];
      end
    end
  end

  // read side, jtag offset returns the input half of the exchange
  always_comb begin
    prdata_o = '0;
    case (reg_off)
      CTRL_VERSION:  prdata_o = SOC_VERSION;
      CTRL_BOOTADDR: prdata_o = fc_bootaddr_o;
      CTRL_FETCH_EN: prdata_o[0] = fc_fetchen_o;
      CTRL_JTAG:     prdata_o[JTAG_REG_WIDTH-1:0] = soc_jtag_reg_i;
      default:       prdata_o = '0;
    endcase
  end

endmodule

//--- source/soc_peripherals.sv
`timescale 1ns/100ps
// peripheral subsystem top, wires APB decoder to gpio, timer and soc control and builds fc events
module soc_peripherals
  import soc_periph_pkg::*;
(
  input  logic                      clk_i,
  input  logic                      arst_n_i,
  input  logic                      slow_clk_i,
  input  logic                      stoptimer_i,
  // apb slave port
  input  logic [APB_ADDR_WIDTH-1:0] paddr_i,
  input  logic [APB_DATA_WIDTH-1:0] pwdata_i,
  input  logic                      pwrite_i,
  input  logic                      psel_i,
  input  logic                      penable_i,
  output logic [APB_DATA_WIDTH-1:0] prdata_o,
  output logic                      pready_o,
  output logic                      pslverr_o,
  // soc control pins
  input  logic                      fc_fetch_en_valid_i,
  input  logic                      fc_fetch_en_i,
  input  logic [JTAG_REG_WIDTH-1:0] soc_jtag_reg_i,
  output logic [APB_DATA_WIDTH-1:0] fc_bootaddr_o,
  output logic                      fc_fetchen_o,
  output logic [JTAG_REG_WIDTH-1:0] soc_jtag_reg_o,
  // gpio pins
  input  logic [N_GPIO-1:0]         gpio_in_i,
  output logic [N_GPIO-1:0]         gpio_out_o,
  output logic [N_GPIO-1:0]         gpio_oe_o,
  output logic [N_FC_EVENTS-1:0]    fc_events_o
);

  logic                      s_psel_gpio;
  logic                      s_psel_timer;
  logic                      s_psel_ctrl;
  logic [APB_DATA_WIDTH-1:0] s_prdata_gpio;
  logic [APB_DATA_WIDTH-1:0] s_prdata_timer;
  logic [APB_DATA_WIDTH-1:0] s_prdata_ctrl;
  logic                      s_gpio_event;
  logic                      s_timer_event;
  logic                      s_ref_edge_event;

  //////////////////////////////////////////////////
  // event vector
  //////////////////////////////////////////////////
  always_comb begin
    fc_events_o                     = '0;
    // one timer irq feeds both mtime and timer lines
    fc_events_o[FC_EVT_TIMER_MTIME] = s_timer_event;
    fc_events_o[FC_EVT_TIMER]       = s_timer_event;
    fc_events_o[FC_EVT_REF_EDGE]    = s_ref_edge_event;
    fc_events_o[FC_EVT_GPIO]        = s_gpio_event;
  end

  periph_bus_decoder i_periph_bus_decoder (
    .paddr_i        (paddr_i),
    .pwrite_i       (pwrite_i),
    .psel_i         (psel_i),
    .penable_i      (penable_i),
    .prdata_gpio_i  (s_prdata_gpio),
    .prdata_timer_i (s_prdata_timer),
    .prdata_ctrl_i  (s_prdata_ctrl),
    .psel_gpio_o    (s_psel_gpio),
    .psel_timer_o   (s_psel_timer),
    .psel_ctrl_o    (s_psel_ctrl),
    .prdata_o       (prdata_o),
    .pready_o       (pready_o),
    .pslverr_o      (pslverr_o)
  );

  apb_gpio i_apb_gpio (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .psel_i       (s_psel_gpio),
    .penable_i    (penable_i),
    .pwrite_i     (pwrite_i),
    .paddr_i      (paddr_i),
    .pwdata_i     (pwdata_i),
    .gpio_in_i    (gpio_in_i),
    .prdata_o     (s_prdata_gpio),
    .gpio_out_o   (gpio_out_o),
    .gpio_oe_o    (gpio_oe_o),
    .gpio_event_o (s_gpio_event)
  );

  apb_timer i_apb_timer (
    .clk_i            (clk_i),
    .arst_n_i         (arst_n_i),
    .psel_i           (s_psel_timer),
    .penable_i        (penable_i),
    .pwrite_i         (pwrite_i),
    .paddr_i          (paddr_i),
    .pwdata_i         (pwdata_i),
    .slow_clk_i       (slow_clk_i),
    .stoptimer_i      (stoptimer_i),
    .prdata_o         (s_prdata_timer),
    .timer_event_o    (s_timer_event),
    .ref_edge_event_o (s_ref_edge_event)
  );

  apb_soc_ctrl i_apb_soc_ctrl (
    .clk_i               (clk_i),
    .arst_n_i            (arst_n_i),
    .psel_i              (s_psel_ctrl),
    .penable_i           (penable_i),
    .pwrite_i            (pwrite_i),
    .paddr_i             (paddr_i),
    .pwdata_i            (pwdata_i),
    .fc_fetch_en_valid_i (fc_fetch_en_valid_i),
    .fc_fetch_en_i       (fc_fetch_en_i),
    .soc_jtag_reg_i      (soc_jtag_reg_i),
    .prdata_o            (s_prdata_ctrl),
    .fc_bootaddr_o       (fc_bootaddr_o),
    .fc_fetchen_o        (fc_fetchen_o),
    .soc_jtag_reg_o      (soc_jtag_reg_o)
  );

endmodule

//--- tb/tb_clk_gen.sv
// testbench clock, reset and divided slow clock, instantiated by the testbench top
`timescale 1ns/100ps
module tb_clk_gen (
  output logic clk_o,
  output logic arst_n_o,
  output logic slow_clk_o
);

  localparam int unsigned PERIOD_NS    = 100;
  localparam int unsigned RESET_CYCLES = 8;
  // slow clock is clk divided by 16
  localparam int unsigned SLOW_HALF    = 8;

  int unsigned div_cnt;

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  // reset held low for the first cycles
  initial begin
    arst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    arst_n_o <= 1'b1;
  end

  initial begin
    slow_clk_o = 1'b0;
    div_cnt    = 0;
  end

  // toggle every half period of the slow clock
  always @(posedge clk_o) begin
    if (div_cnt == SLOW_HALF - 1) begin
      div_cnt    <= 0;
      slow_clk_o <= ~slow_clk_o;
    end else begin
      div_cnt <= div_cnt + 1;
    end
  end

endmodule

//--- tb/tb_soc_peripherals.sv
// testbench for the peripheral subsystem that drives APB and pins and checks results with assertions
`timescale 1ns/100ps
module tb_soc_peripherals;

  //////////////////////////////////////////////////
  // register addresses with the region in [15:12]
  //////////////////////////////////////////////////
  localparam logic [31:0] A_GPIO_DIR        = 32'h0000_0000;
  localparam logic [31:0] A_GPIO_OUT        = 32'h0000_0004;
  localparam logic [31:0] A_GPIO_IN         = 32'h0000_0008;
  localparam logic [31:0] A_GPIO_INT_EN     = 32'h0000_000C;
  localparam logic [31:0] A_GPIO_INT_STATUS = 32'h0000_0010;
  localparam logic [31:0] A_TIMER_CFG       = 32'h0000_1000;
  localparam logic [31:0] A_TIMER_COUNT     = 32'h0000_1004;
  localparam logic [31:0] A_TIMER_CMP       = 32'h0000_1008;
  localparam logic [31:0] A_CTRL_VERSION    = 32'h0000_2000;
  localparam logic [31:0] A_CTRL_BOOTADDR   = 32'h0000_2004;
  localparam logic [31:0] A_CTRL_FETCH_EN   = 32'h0000_2008;
  localparam logic [31:0] A_CTRL_JTAG       = 32'h0000_200C;

  // expected constants and event bits
  localparam logic [31:0] EXP_VERSION   = 32'h0001_0002;
  localparam logic [31:0] EXP_BOOT_ADDR = 32'h1A00_0080;
  localparam int EVT_MTIME = 7;
  localparam int EVT_TIMER = 16;
  localparam int EVT_REF   = 23;
  localparam int EVT_GPIO  = 24;
  localparam logic [31:0] EVT_MASK = (32'h1 << EVT_MTIME) | (32'h1 << EVT_TIMER) |
                                     (32'h1 << EVT_REF) | (32'h1 << EVT_GPIO);
  localparam int APB_TIMEOUT = 16;

  logic        clk;
  logic        arst_n;
  logic        slow_clk;
  logic        stoptimer_i;
  logic [31:0] paddr_i;
  logic [31:0] pwdata_i;
  logic        pwrite_i;
  logic        psel_i;
  logic        penable_i;
  logic [31:0] prdata_o;
  logic        pready_o;
  logic        pslverr_o;
  logic        fc_fetch_en_valid_i;
  logic        fc_fetch_en_i;
  logic [7:0]  soc_jtag_reg_i;
  logic [31:0] fc_bootaddr_o;
  logic        fc_fetchen_o;
  logic [7:0]  soc_jtag_reg_o;
  logic [15:0] gpio_in_i;
  logic [15:0] gpio_out_o;
  logic [15:0] gpio_oe_o;
  logic [31:0] fc_events_o;

  int          errors;
  int          err_mark;
  int          tests_ok;
  int          tests_bad;
  int          cycle;
  int unsigned seed_dummy;

  tb_clk_gen i_tb_clk_gen (
    .clk_o      (clk),
    .arst_n_o   (arst_n),
    .slow_clk_o (slow_clk)
  );

  soc_peripherals i_soc_peripherals (
    .clk_i               (clk),
    .arst_n_i            (arst_n),
    .slow_clk_i          (slow_clk),
    .stoptimer_i         (stoptimer_i),
    .paddr_i             (paddr_i),
    .pwdata_i            (pwdata_i),
    .pwrite_i            (pwrite_i),
    .psel_i              (psel_i),
    .penable_i           (penable_i),
    .prdata_o            (prdata_o),
    .pready_o            (pready_o),
    .pslverr_o           (pslverr_o),
    .fc_fetch_en_valid_i (fc_fetch_en_valid_i),
    .fc_fetch_en_i       (fc_fetch_en_i),
    .soc_jtag_reg_i      (soc_jtag_reg_i),
    .fc_bootaddr_o       (fc_bootaddr_o),
    .fc_fetchen_o        (fc_fetchen_o),
    .soc_jtag_reg_o      (soc_jtag_reg_o),
    .gpio_in_i           (gpio_in_i),
    .gpio_out_o          (gpio_out_o),
    .gpio_oe_o           (gpio_oe_o),
    .fc_events_o         (fc_events_o)
  );

  // free running cycle count for pulse spacing
  initial cycle = 0;
  always @(posedge clk) cycle = cycle + 1;

  // always-on checks sampled mid-cycle
  always @(negedge clk) begin
    if (arst_n === 1'b1) begin
      assert (fc_events_o[EVT_MTIME] === fc_events_o[EVT_TIMER]) else begin
        $display("FAILED fc_events_o[7]: expected 0x%h, got 0x%h",
                 fc_events_o[EVT_TIMER], fc_events_o[EVT_MTIME]);
        errors++;
      end
      assert ((fc_events_o & ~EVT_MASK) === 32'h0) else begin
        $display("FAILED fc_events_o: expected 0x%h, got 0x%h",
                 fc_events_o & EVT_MASK, fc_events_o);
        errors++;
      end
      assert (pready_o === 1'b1) else begin
        $display("FAILED pready_o: expected 0x1, got 0x%h", pready_o);
        errors++;
      end
    end
  end

  //////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////
  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      $display("FAILED %s: expected 0x%h, got 0x%h", name, exp, act);
      errors++;
    end
  endtask

  task automatic end_test(input string name);
    if (errors == err_mark) begin
      tests_ok++;
      $display("test %s: ok", name);
    end else begin
      tests_bad++;
      $display("test %s: %0d errors", name, errors - err_mark);
    end
  endtask

  // access cycle ends once pready is seen
  task automatic wait_ready();
    int n;
    bit ok;
    ok = 1'b0;
    n  = 0;
    while (!ok && n < APB_TIMEOUT) begin
      @(negedge clk);
      if (pready_o === 1'b1) begin
        ok = 1'b1;
      end else begin
        @(posedge clk);
        n++;
      end
    end
    if (!ok) begin
      $display("timeout: pready_o stayed low for %0d cycles", APB_TIMEOUT);
      errors++;
    end
  endtask

  task automatic wait_event(input int idx, input int limit, output bit seen);
    int n;
    seen = 1'b0;
    n    = 0;
    while (!seen && n < limit) begin
      @(negedge clk);
      seen = fc_events_o[idx];
      n++;
    end
    if (!seen) begin
      $display("timeout: fc_events_o[%0d] did not rise within %0d cycles", idx, limit);
      errors++;
    end
  endtask

  // setup then access with the write landing on the closing edge
  task automatic apb_write(input logic [31:0] addr, input logic [31:0] data, output logic err);
    @(posedge clk);
    paddr_i   <= addr;
    pwdata_i  <= data;
    pwrite_i  <= 1'b1;
    psel_i    <= 1'b1;
    penable_i <= 1'b0;
    @(posedge clk);
    penable_i <= 1'b1;
    wait_ready();
    err = pslverr_o;
    @(posedge clk);
    psel_i    <= 1'b0;
    penable_i <= 1'b0;
    pwrite_i  <= 1'b0;
  endtask

  task automatic apb_read(input logic [31:0] addr, output logic [31:0] data, output logic err);
    @(posedge clk);
    paddr_i   <= addr;
    pwrite_i  <= 1'b0;
    psel_i    <= 1'b1;
    penable_i <= 1'b0;
    @(posedge clk);
    penable_i <= 1'b1;
    wait_ready();
    // read data is combinational in the access cycle
    data = prdata_o;
    err  = pslverr_o;
    @(posedge clk);
    psel_i    <= 1'b0;
    penable_i <= 1'b0;
  endtask

  //////////////////////////////////////////////////
  // tests
  //////////////////////////////////////////////////
  task automatic test_reset();
    logic [31:0] rd;
    logic        err;
    int          n;
    err_mark = errors;
    n = 0;
    while (arst_n !== 1'b1 && n < 20) begin
      @(negedge clk);
      n++;
    end
    if (arst_n !== 1'b1) begin
      $display("timeout: reset was never released");
      errors++;
    end
    check_val("fc_fetchen_o", 32'h0, fc_fetchen_o);
    check_val("gpio_oe_o", 32'h0, gpio_oe_o);
    check_val("gpio_out_o", 32'h0, gpio_out_o);
    check_val("soc_jtag_reg_o", 32'h0, soc_jtag_reg_o);
    check_val("fc_events_o", 32'h0, fc_events_o);
    check_val("fc_bootaddr_o", EXP_BOOT_ADDR, fc_bootaddr_o);
    apb_read(A_CTRL_VERSION, rd, err);
    check_val("prdata_o", EXP_VERSION, rd);
    check_val("pslverr_o", 32'h0, err);
    end_test("reset_and_version");
  endtask

  task automatic test_gpio_regs();
    logic [31:0] dir;
    logic [31:0] out;
    logic [15:0] pins;
    logic [31:0] rd;
    logic        err;
    err_mark = errors;
    dir  = $urandom;
    out  = $urandom;
    pins = $urandom;
    apb_write(A_GPIO_DIR, dir, err);
    apb_write(A_GPIO_OUT, out, err);
    @(negedge clk);
    check_val("gpio_oe_o", dir[15:0], gpio_oe_o);
    check_val("gpio_out_o", out[15:0], gpio_out_o);
    apb_read(A_GPIO_DIR, rd, err);
    check_val("prdata_o", {16'h0, dir[15:0]}, rd);
    apb_read(A_GPIO_OUT, rd, err);
    check_val("prdata_o", {16'h0, out[15:0]}, rd);
    // pins pass the 2-flop sync first
    @(posedge clk);
    gpio_in_i <= pins;
    repeat (3) @(posedge clk);
    apb_read(A_GPIO_IN, rd, err);
    check_val("prdata_o", {16'h0, pins}, rd);
    end_test("gpio_regs");
  endtask

  task automatic test_gpio_irq();
    int          p;
    int          q;
    int          k;
    bit          seen;
    logic [31:0] rd;
    logic        err;
    err_mark = errors;
    p = $urandom % 16;
    // q differs from p
    q = (p + 1 + ($urandom % 15)) % 16;
    @(posedge clk);
    gpio_in_i <= '0;
    repeat (4) @(posedge clk);
    apb_write(A_GPIO_INT_EN, 32'h1 << p, err);
    // disabled pin must stay quiet
    @(posedge clk);
    gpio_in_i <= 16'h1 << q;
    seen = 1'b0;
    for (k = 0; k < 8; k++) begin
      @(negedge clk);
      seen = seen | fc_events_o[EVT_GPIO];
    end
    check_val("fc_events_o[24]", 32'h0, seen);
    @(posedge clk);
    gpio_in_i <= (16'h1 << q) | (16'h1 << p);
    wait_event(EVT_GPIO, 10, seen);
    // write one to clear
    apb_write(A_GPIO_INT_STATUS, 32'h1 << p, err);
    @(negedge clk);
    check_val("fc_events_o[24]", 32'h0, fc_events_o[EVT_GPIO]);
    apb_read(A_GPIO_INT_STATUS, rd, err);
    check_val("prdata_o", 32'h0, rd);
    end_test("gpio_irq");
  endtask

  task automatic test_timer();
    logic [31:0] cmp;
    logic [31:0] rd;
    logic [31:0] cnt_a;
    logic        err;
    int          t_prev;
    int          k;
    bit          seen;
    err_mark = errors;
    cmp = 32'd1 + ($urandom % 63);
    apb_write(A_TIMER_CMP, cmp, err);
    apb_write(A_TIMER_COUNT, 32'h0, err);
    // enable in clock mode
    apb_write(A_TIMER_CFG, 32'h1, err);
    wait_event(EVT_TIMER, 200, seen);
    t_prev = cycle;
    for (k = 0; k < 3; k++) begin
      @(negedge clk);
      check_val("fc_events_o[16]", 32'h0, fc_events_o[EVT_TIMER]);
      wait_event(EVT_TIMER, 200, seen);
      check_val("fc_events_o[16] period", cmp + 1, cycle - t_prev);
      t_prev = cycle;
    end
    // one pulse may still leave on the stop edge
    @(posedge clk);
    stoptimer_i <= 1'b1;
    @(posedge clk);
    apb_read(A_TIMER_COUNT, cnt_a, err);
    seen = 1'b0;
    for (k = 0; k < 2 * cmp + 4; k++) begin
      @(negedge clk);
      seen = seen | fc_events_o[EVT_TIMER];
    end
    check_val("fc_events_o[16]", 32'h0, seen);
    apb_read(A_TIMER_COUNT, rd, err);
    check_val("prdata_o", cnt_a, rd);
    @(posedge clk);
    stoptimer_i <= 1'b0;
    apb_write(A_TIMER_CFG, 32'h0, err);
    end_test("timer");
  endtask

  task automatic test_soc_ctrl();
    logic [31:0] boot;
    logic [7:0]  jin;
    logic [7:0]  jout;
    logic [31:0] rd;
    logic        err;
    err_mark = errors;
    boot = $urandom;
    jin  = $urandom;
    jout = $urandom;
    apb_write(A_CTRL_BOOTADDR, boot, err);
    @(negedge clk);
    check_val("fc_bootaddr_o", boot, fc_bootaddr_o);
    apb_write(A_CTRL_FETCH_EN, 32'h1, err);
    @(negedge clk);
    check_val("fc_fetchen_o", 32'h1, fc_fetchen_o);
    // pin strobe overrides the register
    @(posedge clk);
    fc_fetch_en_valid_i <= 1'b1;
    fc_fetch_en_i       <= 1'b0;
    @(posedge clk);
    fc_fetch_en_valid_i <= 1'b0;
    @(negedge clk);
    check_val("fc_fetchen_o", 32'h0, fc_fetchen_o);
    @(posedge clk);
    soc_jtag_reg_i <= jin;
    apb_read(A_CTRL_JTAG, rd, err);
    check_val("prdata_o", {24'h0, jin}, rd);
    apb_write(A_CTRL_JTAG, {24'h0, jout}, err);
    @(negedge clk);
    check_val("soc_jtag_reg_o", jout, soc_jtag_reg_o);
    end_test("soc_ctrl");
  endtask

  task automatic test_decode_ref();
    logic [3:0]  region;
    logic [31:0] addr;
    logic [31:0] rd;
    logic        err;
    logic [31:0] boot_before;
    logic [15:0] out_before;
    logic        slow_prev;
    logic        evt_prev;
    int          k;
    int          edges;
    int          pulses;
    err_mark = errors;
    // regions 3 to 15 are unmapped
    region = 4'd3 + ($urandom % 13);
    addr   = {16'h0, region, 12'h004};
    @(negedge clk);
    boot_before = fc_bootaddr_o;
    out_before  = gpio_out_o;
    apb_read(addr, rd, err);
    check_val("pslverr_o", 32'h1, err);
    check_val("prdata_o", 32'h0, rd);
    apb_write(addr, $urandom, err);
    check_val("pslverr_o", 32'h1, err);
    @(negedge clk);
    check_val("fc_bootaddr_o", boot_before, fc_bootaddr_o);
    check_val("gpio_out_o", out_before, gpio_out_o);
    // count slow edges against ref edge pulses
    edges     = 0;
    pulses    = 0;
    slow_prev = slow_clk;
    evt_prev  = fc_events_o[EVT_REF];
    for (k = 0; k < 160; k++) begin
      @(negedge clk);
      if (slow_clk !== slow_prev) begin
        edges++;
      end
      if (fc_events_o[EVT_REF] && !evt_prev) begin
        pulses++;
      end
      assert (!(fc_events_o[EVT_REF] && evt_prev)) else begin
        $display("pulse on fc_events_o[23] lasted longer than one cycle");
        errors++;
      end
      slow_prev = slow_clk;
      evt_prev  = fc_events_o[EVT_REF];
    end
    // one edge may be in flight at either end
    assert (edges > 0 && edges - pulses <= 1 && pulses - edges <= 1) else begin
      $display("%0d ref edge pulses do not match %0d slow clock edges", pulses, edges);
      errors++;
    end
    end_test("decode_and_ref_edge");
  endtask

  //////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////
  initial begin
    seed_dummy          = $urandom(32'h3fa5);
    errors              = 0;
    err_mark            = 0;
    tests_ok            = 0;
    tests_bad           = 0;
    stoptimer_i         = 1'b0;
    paddr_i             = '0;
    pwdata_i            = '0;
    pwrite_i            = 1'b0;
    psel_i              = 1'b0;
    penable_i           = 1'b0;
    fc_fetch_en_valid_i = 1'b0;
    fc_fetch_en_i       = 1'b0;
    soc_jtag_reg_i      = '0;
    gpio_in_i           = '0;
    test_reset();
    test_gpio_regs();
    test_gpio_irq();
    test_timer();
    test_soc_ctrl();
    test_decode_ref();
    $display("tests passed: %0d, tests failed: %0d, errors: %0d", tests_ok, tests_bad, errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

//--- flist.f
common/soc_periph_pkg.sv
source/periph_bus_decoder.sv
gpio/apb_gpio.sv
timer/apb_timer.sv
source/apb_soc_ctrl.sv
source/soc_peripherals.sv
tb/tb_clk_gen.sv
tb/tb_soc_peripherals.sv
